// ==== hdl/cmd_decoder.sv ====
`default_nettype none

module cmd_decoder import pkt_gen_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_valid,
    input  cmd_word_u cmd_data,
    input  logic      cmd_last,
    output gen_cfg_t  cfg,
    output logic      trigger
);

    logic        first;     // Next beat opens a command frame
    logic        accept;
    logic [31:0] arg4;
    logic [15:0] arg6;

    assign accept = cmd_valid && first;

    // Arguments come in most significant byte first
    assign arg4 = {<<8{cmd_data.tag4.arg}};
    assign arg6 = {<<8{cmd_data.tag6.arg}};

    // --------------------
    // Frame start tracking
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            first <= 1'b1;
        end else if (cmd_valid) begin
            first <= cmd_last;
        end
    end

    // --------------------
    // Keyword decode
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            trigger <= 1'b0;
            cfg     <= '{
                run_en:      1'b0,
                random_en:   1'b0,
                frame_count: DEF_FRAME_COUNT,
                err_every:   32'd0,
                err_pos:     DEF_ERR_POS
            };
        end else begin
            trigger <= 1'b0;
            if (accept) begin
                // Back to back triggers collapse into one pulse
                if (cmd_data.whole == KEY_TRIGGER) begin
                    trigger <= !trigger;
                end

                // Start / stop
                if (cmd_data.tag4.key == KEY_RUN_TAG) begin
                    if (cmd_data.tag4.arg == KEY_INIT) begin
                        cfg.run_en <= 1'b1;
                    end else if (cmd_data.tag4.arg == KEY_FINI) begin
                        cfg.run_en <= 1'b0;
                    end
                end

                if (cmd_data.tag7.key == KEY_RANDOM) begin
                    if (cmd_data.tag7.sel == KEY_LOOPLESS_E_CHAR) begin
                        cfg.random_en <= 1'b1;
                    end else if (cmd_data.tag7.sel == KEY_D_CHAR) begin
                        cfg.random_en <= 1'b0;
                    end
                end

                if (cmd_data.tag4.key == KEY_PKT) begin
                    cfg.frame_count <= arg4;     // Frames per burst
                end
                if (cmd_data.tag4.key == KEY_ERR) begin
                    cfg.err_every <= arg4;
                end
                if (cmd_data.tag6.key == KEY_ERR_P) begin
                    cfg.err_pos <= arg6;         // Word index of the test word
                end
            end
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_trigger_single : assert property (
        @(posedge clk) disable iff (rst)
        trigger |=> !trigger
    ) else $error("trigger high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== hdl/frame_sequencer.sv ====
`default_nettype none

module frame_sequencer import pkt_gen_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  gen_cfg_t          cfg,
    input  logic              trigger,
    input  logic [DATA_W-1:0] word,
    output stream_t           out,
    output logic              out_valid,
    input  logic              out_ready,
    output logic              busy,
    output word_kind_e        kind,
    output logic [31:0]       frame_idx,
    output logic              load,
    output logic              burst_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_STREAM,
        S_GAP
    } state_e;

    state_e           state;
    logic [IDX_W-1:0] idx;       // Word on the output
    logic [IDX_W-1:0] next_idx;
    logic [GAP_W-1:0] gap_cnt;
    logic [31:0]      err_cnt;   // frame_idx + 1 modulo err_every
    logic             last_q;
    logic             fire;
    logic             frame_end;
    logic             burst_end;
    logic             start;
    logic             restart;
    logic             test_frame;

    assign fire       = out_valid && out_ready;
    assign frame_end  = fire && (idx == IDX_W'(FRAME_WORDS - 1));
    assign burst_end  = frame_end &&
                        ((frame_idx + 32'd1 >= cfg.frame_count) || !cfg.run_en);
    assign start      = (state == S_IDLE) && trigger && cfg.run_en;
    assign restart    = (state == S_GAP) && (gap_cnt == GAP_W'(GAP_CYCLES - 1));
    assign next_idx   = (state == S_STREAM) ? idx + 1'b1 : '0;
    assign test_frame = (cfg.err_every != 32'd0) && (err_cnt == cfg.err_every);

    // Next word is fetched as the current one leaves
    assign load       = start || restart || (fire && !frame_end);
    assign burst_done = burst_end;
    assign busy       = (state != S_IDLE);

    assign out.data = word;
    assign out.last = last_q;

    // --------------------
    // Word kind per index
    // --------------------
    always_comb begin
        if (next_idx == '0 || next_idx == IDX_W'(FRAME_WORDS - 1)) begin
            kind = KIND_STAMP;
        end else if (next_idx == IDX_W'(1)) begin
            kind = KIND_HEADER;
        end else if (test_frame && (16'(next_idx) == cfg.err_pos)) begin
            kind = KIND_TEST;
        end else begin
            kind = KIND_PAYLOAD;
        end
    end

    // --------------------
    // Burst / frame FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            out_valid <= 1'b0;
            idx       <= '0;
            last_q    <= 1'b0;
            gap_cnt   <= '0;
            frame_idx <= 32'd0;
            err_cnt   <= 32'd1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin  // Triggers while busy never get here
                        state     <= S_STREAM;
                        out_valid <= 1'b1;
                        idx       <= '0;
                        last_q    <= 1'b0;
                        frame_idx <= 32'd0;
                        err_cnt   <= 32'd1;
                    end
                end
                S_STREAM: begin
                    if (frame_end) begin
                        out_valid <= 1'b0;
                        last_q    <= 1'b0;
                        gap_cnt   <= '0;
                        if (burst_end) begin
                            state <= S_IDLE;
                        end else begin
                            state     <= S_GAP;
                            frame_idx <= frame_idx + 32'd1;
                            err_cnt   <= (err_cnt >= cfg.err_every) ? 32'd1 : err_cnt + 32'd1;
                        end
                    end else if (fire) begin
                        idx    <= next_idx;
                        last_q <= (next_idx == IDX_W'(FRAME_WORDS - 1));
                    end
                end
                S_GAP: begin
                    if (restart) begin
                        state     <= S_STREAM;
                        out_valid <= 1'b1;   // Start stamp loads this cycle
                        idx       <= '0;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_hold_beat : assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out)
    ) else $error("output beat changed while stalled");

    a_last_pos : assert property (
        @(posedge clk) disable iff (rst)
        out_valid && out.last |-> idx == IDX_W'(FRAME_WORDS - 1)
    ) else $error("last flag away from the final word");

endmodule

`default_nettype wire

// ==== hdl/payload_source.sv ====
`default_nettype none

module payload_source import pkt_gen_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  gen_cfg_t          cfg,
    input  word_kind_e        kind,
    input  logic [31:0]       frame_idx,
    input  logic              load,
    input  logic              burst_done,
    output logic [DATA_W-1:0] word
);

    logic [63:0] timestamp;
    logic [63:0] pattern;    // Counting payload
    logic [63:0] lfsr;
    logic        feedback;
    logic        use_pattern;
    logic        use_lfsr;

    // x^64 + x^63 + x^61 + x^60 + 1
    assign feedback = lfsr[63] ^ lfsr[62] ^ lfsr[60] ^ lfsr[59];

    assign use_pattern = load && (kind == KIND_PAYLOAD) && !cfg.random_en;
    assign use_lfsr    = load && (kind == KIND_PAYLOAD) && cfg.random_en;

    // --------------------
    // Generators
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            timestamp <= 64'd0;
            pattern   <= 64'd0;
            lfsr      <= LFSR_SEED;
        end else begin
            timestamp <= timestamp + 64'd1;  // Free running

            if (burst_done) begin
                pattern <= 64'd0;
            end else if (use_pattern) begin
                pattern <= pattern + 64'd1;
            end

            // Advances per random word only, kept across bursts
            if (use_lfsr) begin
                lfsr <= {lfsr[62:0], feedback};
            end
        end
    end

    // --------------------
    // Output word
    // --------------------
    always_ff @(posedge clk) begin
        if (load) begin
            case (kind)
                KIND_STAMP:   word <= timestamp;
                KIND_HEADER:  word <= {frame_idx, cfg.frame_count};
                KIND_TEST:    word <= TEST_WORD;
                KIND_PAYLOAD: word <= cfg.random_en ? lfsr : pattern;
                default:      word <= pattern;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pkt_gen_pkg.sv ====
`default_nettype none

package pkt_gen_pkg;

    // --------------------
    // Datapath and framing
    // --------------------
    localparam int DATA_W      = 64;
    localparam int FRAME_WORDS = 1024;                // 8192 bytes per frame
    localparam int GAP_CYCLES  = 20;                  // Idle cycles between frames
    localparam int IDX_W       = $clog2(FRAME_WORDS);
    localparam int GAP_W       = $clog2(GAP_CYCLES);

    localparam logic [31:0] DEF_FRAME_COUNT = 32'd128;
    localparam logic [15:0] DEF_ERR_POS     = 16'd128;

    localparam logic [63:0] LFSR_SEED = 64'h0123456789ABCDEF;
    localparam logic [63:0] TEST_WORD = 64'h0A2E545345542E0A;  // "\n.TEST.\n"

    // --------------------
    // Command keywords
    // --------------------
    // ASCII text, first character in the lowest byte
    localparam logic [63:0] KEY_TRIGGER         = 64'h5F52454747495254;  // "TRIGGER_"
    localparam logic [31:0] KEY_RUN_TAG         = 32'h2E2E2E2E;          // "...."
    localparam logic [31:0] KEY_INIT            = 32'h54494E49;          // "INIT"
    localparam logic [31:0] KEY_FINI            = 32'h494E4946;          // "FINI"
    localparam logic [55:0] KEY_RANDOM          = 56'h5F4D4F444E4152;    // "RANDOM_"
    localparam logic [7:0]  KEY_LOOPLESS_E_CHAR = 8'h45;                 // "E"
    localparam logic [7:0]  KEY_D_CHAR          = 8'h44;                 // "D"
    localparam logic [31:0] KEY_PKT             = 32'h23544B50;          // "PKT#"
    localparam logic [31:0] KEY_ERR             = 32'h23525245;          // "ERR#"
    localparam logic [47:0] KEY_ERR_P           = 48'h23505F525245;      // "ERR_P#"

    // --------------------
    // Command word views
    // --------------------
    typedef struct packed {
        logic [31:0] arg;   // MSB first on the wire
        logic [31:0] key;
    } tag4_t;

    typedef struct packed {
        logic [15:0] arg;
        logic [47:0] key;
    } tag6_t;

    typedef struct packed {
        logic [7:0]  sel;   // Selector character
        logic [55:0] key;
    } tag7_t;

    typedef union packed {
        tag4_t       tag4;
        tag6_t       tag6;
        tag7_t       tag7;
        logic [63:0] whole;
    } cmd_word_u;

    // Generator configuration
    typedef struct packed {
        logic        run_en;
        logic        random_en;
        logic [31:0] frame_count;
        logic [31:0] err_every;     // 0 disables the test word
        logic [15:0] err_pos;
    } gen_cfg_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } stream_t;

    typedef enum logic [1:0] {
        KIND_STAMP,
        KIND_HEADER,
        KIND_PAYLOAD,
        KIND_TEST
    } word_kind_e;

endpackage

`default_nettype wire

// ==== hdl/pkt_gen_top.sv ====
`default_nettype none

module pkt_gen_top import pkt_gen_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // Received command payload
    input  logic              cmd_valid,
    input  logic [DATA_W-1:0] cmd_data,
    input  logic              cmd_last,

    // Generated frames
    output logic [DATA_W-1:0] out_data,
    output logic              out_last,
    output logic              out_valid,
    input  logic              out_ready,

    // Board LEDs
    output logic              busy,
    output logic              run_en
);

    gen_cfg_t          cfg;
    logic              trigger;
    word_kind_e        kind;
    logic [31:0]       frame_idx;
    logic              load;
    logic              burst_done;
    logic [DATA_W-1:0] word;
    stream_t           out;

    assign out_data = out.data;
    assign out_last = out.last;
    assign run_en   = cfg.run_en;

    cmd_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_data  (cmd_data),
        .cmd_last  (cmd_last),
        .cfg       (cfg),
        .trigger   (trigger)
    );

    frame_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .trigger    (trigger),
        .word       (word),
        .out        (out),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .busy       (busy),
        .kind       (kind),
        .frame_idx  (frame_idx),
        .load       (load),
        .burst_done (burst_done)
    );

    payload_source u_payload (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .kind       (kind),
        .frame_idx  (frame_idx),
        .load       (load),
        .burst_done (burst_done),
        .word       (word)
    );

endmodule

`default_nettype wire

// ==== tb/tb_pkt_gen.sv ====
`default_nettype none

module tb_pkt_gen
    import pkt_gen_pkg::*;
();

    logic              clk;
    logic              rst;
    logic              cmd_valid;
    logic [DATA_W-1:0] cmd_data;
    logic              cmd_last;
    logic [DATA_W-1:0] out_data;
    logic              out_last;
    logic              out_valid;
    logic              out_ready;
    logic              busy;
    logic              run_en;

    // Reference model state
    logic        m_run;
    logic        m_random;
    logic [31:0] m_count;
    logic [31:0] m_err_every;
    logic [15:0] m_err_pos;
    logic [63:0] m_lfsr;
    logic [63:0] prev_end;    // Last end stamp seen
    logic [31:0] rng_state;
    logic        stall_en;
    string       test_name;

    pkt_gen_top DUT (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_data  (cmd_data),
        .cmd_last  (cmd_last),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (busy),
        .run_en    (run_en)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Text reads left to right, first character goes to the lowest byte
    function automatic logic [63:0] wire_order(input logic [63:0] text);
        return {<<8{text}};
    endfunction

    // Taps 63, 62, 60, 59
    function automatic logic [63:0] lfsr_step(input logic [63:0] s);
        return {s[62:0], s[63] ^ s[62] ^ s[60] ^ s[59]};
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (actual !== expected) begin
            abort($sformatf("MISMATCH %s %s: expected %h, actual %h",
                            test_name, what, expected, actual));
        end
    endtask

    task automatic send_cmd(input logic [63:0] text);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_data  = wire_order(text);
        cmd_last  = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd_last  = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic send_two_beats(input logic [63:0] first, input logic [63:0] second);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_data  = wire_order(first);
        cmd_last  = 1'b0;
        @(negedge clk);
        cmd_data  = wire_order(second);  // Not a command word
        cmd_last  = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd_last  = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare("idle valid", 0, out_valid);
            compare("idle busy", 0, busy);
        end
    endtask

    // Waits for the next transfer, counts the cycles with valid low before it
    task automatic get_beat(output logic [63:0] data, output logic last, output int idle);
        int waited;
        waited = 0;
        idle   = 0;
        do begin
            @(negedge clk);
            out_ready = !stall_en || (next_rand() % 4 != 0);
            if (!out_valid) idle++;
            waited++;
            if (waited > 2000) begin
                abort("Timeout: no output beat arrived");
            end
        end while (!(out_valid && out_ready));
        data = out_data;
        last = out_last;
    endtask

    // --------------------
    // Frame checker
    // --------------------
    task automatic receive_burst(input int frames);
        logic [63:0] data;
        logic [63:0] start;
        logic [63:0] pattern;
        logic        last;
        int          idle;
        int          limit;
        pattern = 64'd0;     // Restarts every burst
        start   = 64'd0;
        for (int f = 0; f < frames; f++) begin
            for (int w = 0; w < FRAME_WORDS; w++) begin
                get_beat(data, last, idle);
                compare("busy", 1, busy);
                compare("last flag", w == FRAME_WORDS - 1, last);
                if (w == 0 && f > 0) begin
                    compare("gap cycles", GAP_CYCLES, idle);
                end else if (w > 0) begin
                    compare("valid dropped in frame", 0, idle);
                end
                if (w == 0) begin
                    compare("start after previous end", 1, data > prev_end);
                    start = data;
                end else if (w == FRAME_WORDS - 1) begin
                    compare("end after start", 1, data > start);
                    prev_end = data;
                end else if (w == 1) begin
                    compare("header", {f[31:0], m_count}, data);
                end else if (m_err_every != 0 && (f + 1) % m_err_every == 0 &&
                             w == m_err_pos) begin
                    compare("test word", wire_order("\n.TEST.\n"), data);
                end else if (m_random) begin
                    compare("random payload", m_lfsr, data);
                    m_lfsr = lfsr_step(m_lfsr);
                end else begin
                    compare("counting payload", pattern, data);
                    pattern++;
                end
            end
        end
        @(negedge clk);
        out_ready = 1'b0;    // Next burst waits here until it is read
        limit = 0;
        while (busy) begin
            @(negedge clk);
            limit++;
            if (limit > 10) begin
                abort("Timeout: busy stayed high after the last frame");
            end
        end
        expect_quiet(GAP_CYCLES + 10);  // No extra frame
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [31:0] n;
        logic [15:0] p;
        rng_state   = 32'd86952;
        rst         = 1'b1;
        cmd_valid   = 1'b0;
        cmd_data    = '0;
        cmd_last    = 1'b0;
        out_ready   = 1'b0;
        stall_en    = 1'b0;
        m_run       = 1'b0;
        m_random    = 1'b0;
        m_count     = 32'd128;
        m_err_every = 32'd0;
        m_err_pos   = 16'd128;
        m_lfsr      = LFSR_SEED;
        prev_end    = 64'd0;
        test_name   = "reset";
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare("run_en", 0, run_en);
        expect_quiet(5);

        test_name = "start_and_size";
        send_cmd("TRIGGER_");             // Not running yet
        expect_quiet(30);
        send_cmd("....INIT");
        m_run = 1'b1;
        compare("run_en", m_run, run_en);
        n = 2 + next_rand() % 3;
        send_cmd({"PKT#", n});
        m_count = n;
        send_cmd("TRIGGER_");
        receive_burst(n);

        test_name = "fini";
        send_cmd({"PKT#", 32'd5});
        m_count = 5;
        send_cmd("TRIGGER_");
        fork
            receive_burst(1);
            begin
                repeat (100) @(negedge clk);
                send_cmd("TRIGGER_");     // Dropped while busy
                repeat (200) @(negedge clk);
                send_cmd("....FINI");
            end
        join
        m_run = 1'b0;
        compare("run_en", m_run, run_en);
        send_cmd("TRIGGER_");
        expect_quiet(30);
        send_cmd("....INIT");
        m_run = 1'b1;

        test_name = "random";
        send_cmd("RANDOM_E");
        m_random = 1'b1;
        send_cmd({"PKT#", 32'd2});
        m_count = 2;
        repeat (2) begin
            send_cmd("TRIGGER_");
            receive_burst(2);
        end
        send_cmd("RANDOM_D");
        m_random = 1'b0;
        send_cmd("TRIGGER_");
        receive_burst(2);

        test_name = "test_word";
        n = 1 + next_rand() % 3;
        p = 16'(2 + next_rand() % (FRAME_WORDS - 3));
        send_cmd({"ERR#", n});
        m_err_every = n;
        send_cmd({"ERR_P#", p});
        m_err_pos = p;
        send_cmd({"PKT#", 32'd4});
        m_count = 4;
        send_cmd("TRIGGER_");
        receive_burst(4);
        send_cmd({"ERR#", 32'd0});
        m_err_every = 0;
        send_cmd("TRIGGER_");
        receive_burst(4);

        test_name = "stalls";
        stall_en = 1'b1;
        send_cmd({"ERR#", 32'd2});
        m_err_every = 2;
        send_cmd({"PKT#", 32'd3});
        m_count = 3;
        send_two_beats("NOP_NOP_", {"PKT#", 32'd9});
        send_two_beats("NOP_NOP_", "....FINI");
        send_two_beats("NOP_NOP_", "TRIGGER_");
        send_cmd("BOGUS_CM");
        expect_quiet(20);
        compare("run_en", m_run, run_en);
        send_cmd("TRIGGER_");
        receive_burst(3);
        send_cmd("RANDOM_E");
        m_random = 1'b1;
        send_cmd("TRIGGER_");
        receive_burst(3);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/pkt_gen_pkg.sv
hdl/cmd_decoder.sv
hdl/frame_sequencer.sv
hdl/payload_source.sv
hdl/pkt_gen_top.sv
tb/tb_pkt_gen.sv
